// ==== hdl/axis_pack_pkg.sv ====
package axis_pack_pkg;

    // Byte lanes on the stream data path.
    localparam int lanes = 4;

    // One beat of tdata, lane 0 in the low byte.
    typedef logic [8*lanes-1:0] beat_data_t;

    // One keep bit per lane.
    typedef logic [lanes-1:0] beat_keep_t;

    // Kept bytes in a beat, 0 to lanes; the join reuses it for sums up to 7.
    typedef logic [2:0] byte_count_t;

    // Plain AXI4-Stream beat as seen at the top ports.
    typedef struct packed {
        beat_data_t tdata;      // Payload bytes.
        beat_keep_t tkeep;      // Lane enables.
        logic       tlast;      // End of packet.
    } axis_beat_t;

    // Compacted beat, valid bytes already moved down to lane 0.
    typedef struct packed {
        beat_data_t  tdata;     // Low lanes valid, rest zero.
        byte_count_t count;     // Number of valid low lanes.
        logic        tlast;     // End of packet.
    } packed_beat_t;

endpackage

// ==== hdl/axis_pack_compact.sv ====
module axis_pack_compact (
    input  logic                        aclk,
    input  logic                        areset_n,
    input  axis_pack_pkg::axis_beat_t   rx_beat,
    input  logic                        rx_valid,
    output logic                        rx_ready,
    output axis_pack_pkg::packed_beat_t cj_beat,
    output logic                        cj_valid,
    input  logic                        cj_ready
);
    import axis_pack_pkg::*;

    beat_data_t  gather_data;   // Kept bytes packed toward lane 0.
    byte_count_t gather_count;  // Kept lanes in the current beat.

    // No buffering here, so the stage stalls exactly with the join.
    assign rx_ready = cj_ready;

    // Walk the lanes from the bottom and drop each kept byte into the
    // next free low lane. The running count doubles as the write pointer.
    always_comb begin
        gather_data  = '0;
        gather_count = '0;
        for (int i = 0; i < lanes; i++) begin
            if (rx_beat.tkeep[i]) begin
                gather_data[8*gather_count +: 8] = rx_beat.tdata[8*i +: 8];
                gather_count = gather_count + 1'b1;
            end
        end
    end

    // Valid flag.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            cj_valid <= 1'b0;
        end else if (cj_ready) begin
            cj_valid <= rx_valid;   // Empty slot when rx is idle.
        end
    end

    // Compacted payload.
    always_ff @(posedge aclk) begin
        if (cj_ready) begin
            cj_beat.tdata <= gather_data;
            cj_beat.count <= gather_count;
            cj_beat.tlast <= rx_beat.tlast;
        end
    end

    // A registered beat never claims more bytes than the lanes it has.
    assert property (@(posedge aclk) disable iff (!areset_n)
        cj_valid |-> (cj_beat.count <= lanes))
    else $error("compact count above lane count");

endmodule

// ==== hdl/axis_pack_join.sv ====
module axis_pack_join (
    input  logic                        aclk,
    input  logic                        areset_n,
    input  axis_pack_pkg::packed_beat_t cj_beat,
    input  logic                        cj_valid,
    output logic                        cj_ready,
    output axis_pack_pkg::axis_beat_t   tx_beat,
    output logic                        tx_valid,
    input  logic                        tx_ready
);
    import axis_pack_pkg::*;

    typedef enum logic [1:0] {
        state_aligned,          // Carry buffer empty.
        state_pack,             // Leftover bytes waiting for more input.
        state_flush             // Packet ended with more than one beat pending.
    } join_state_t;

    join_state_t state;
    join_state_t state_next;

    beat_data_t  buf_data;      // Carry bytes in the low lanes, at most 3.
    beat_data_t  buf_data_next;
    byte_count_t buf_count;     // Fill level of the carry buffer.
    byte_count_t buf_count_next;

    logic [2*8*lanes-1:0] wide_data;    // Carry bytes followed by new bytes.
    byte_count_t          total;        // Carry plus new, at most 7.
    byte_count_t          remain;       // Bytes left over after one full beat.

    logic       emit;           // An output beat is produced this edge.
    axis_beat_t emit_beat;

    // Keep mask with the low n lanes set.
    function automatic beat_keep_t keep_of(byte_count_t n);
        beat_keep_t k;
        for (int i = 0; i < lanes; i++) begin
            k[i] = (i < n);
        end
        return k;
    endfunction

    // Input is held off for the single flush cycle only.
    assign cj_ready = tx_ready && (state != state_flush);

    // Append the new beat after the buffered bytes.
    always_comb begin
        wide_data = {{(8*lanes){1'b0}}, cj_beat.tdata} << (8 * buf_count);
        for (int i = 0; i < lanes; i++) begin
            if (i < buf_count) begin
                wide_data[8*i +: 8] = buf_data[8*i +: 8];
            end
        end
        total  = buf_count + cj_beat.count;
        remain = byte_count_t'(total - lanes);
    end

    always_comb begin
        state_next      = state;
        buf_data_next   = buf_data;
        buf_count_next  = buf_count;
        emit            = 1'b0;
        emit_beat.tdata = wide_data[8*lanes-1:0];
        emit_beat.tkeep = '1;
        emit_beat.tlast = 1'b0;

        if (state == state_flush) begin
            // Closing beat with whatever the last packet left behind.
            emit            = 1'b1;
            emit_beat.tdata = buf_data;
            emit_beat.tkeep = keep_of(buf_count);
            emit_beat.tlast = 1'b1;
            buf_count_next  = '0;
            state_next      = state_aligned;
        end else if (cj_valid) begin
            if (cj_beat.tlast && (total <= lanes)) begin
                // Everything fits in one closing beat.
                emit            = (total != 0);    // Empty packet gives nothing.
                emit_beat.tkeep = keep_of(total);
                emit_beat.tlast = 1'b1;
                buf_count_next  = '0;
                state_next      = state_aligned;
            end else if (total >= lanes) begin
                emit           = 1'b1;            // Full beat, tlast comes later.
                buf_data_next  = wide_data[2*8*lanes-1:8*lanes];
                buf_count_next = remain;
                if (cj_beat.tlast) begin
                    state_next = state_flush;
                end else if (remain == 0) begin
                    state_next = state_aligned;
                end else begin
                    state_next = state_pack;
                end
            end else begin
                // Not enough for a beat yet, keep collecting.
                buf_data_next  = wide_data[8*lanes-1:0];
                buf_count_next = total;
                state_next     = (total == 0) ? state_aligned : state_pack;
            end
        end
    end

    // FSM, fill level and output valid.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state     <= state_aligned;
            buf_count <= '0;
            tx_valid  <= 1'b0;
        end else if (tx_ready) begin
            state     <= state_next;
            buf_count <= buf_count_next;
            tx_valid  <= emit;
        end
    end

    // Carry bytes and output payload.
    always_ff @(posedge aclk) begin
        if (tx_ready) begin
            buf_data <= buf_data_next;
            tx_beat  <= emit_beat;
        end
    end

    // Output keep is a run of ones starting at lane 0.
    assert property (@(posedge aclk) disable iff (!areset_n)
        tx_valid |-> ((tx_beat.tkeep != '0) &&
                      ((tx_beat.tkeep & (tx_beat.tkeep + 1'b1)) == '0)))
    else $error("tx keep not contiguous from lane 0");

    // Only the last beat of a packet may be short.
    assert property (@(posedge aclk) disable iff (!areset_n)
        (tx_valid && !tx_beat.tlast) |-> (tx_beat.tkeep == '1))
    else $error("short tx beat without tlast");

    // With the sink ready, input is refused only while flushing.
    assert property (@(posedge aclk) disable iff (!areset_n)
        (tx_ready && !cj_ready) |-> (state == state_flush))
    else $error("cj_ready low outside flush");

endmodule

// ==== hdl/axis_pack.sv ====
module axis_pack (
    input  logic                      aclk,
    input  logic                      areset_n,
    input  axis_pack_pkg::axis_beat_t rx_beat,
    input  logic                      rx_valid,
    output logic                      rx_ready,
    output axis_pack_pkg::axis_beat_t tx_beat,
    output logic                      tx_valid,
    input  logic                      tx_ready
);
    import axis_pack_pkg::*;

    packed_beat_t cj_beat;      // Compacted beat into the join.
    logic         cj_valid;
    logic         cj_ready;     // Follows tx_ready except during flush.

    // Null bytes removed, kept bytes moved to the low lanes.
    axis_pack_compact u_compact (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rx_beat  (rx_beat),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .cj_beat  (cj_beat),
        .cj_valid (cj_valid),
        .cj_ready (cj_ready)
    );

    // Compacted beats merged into full output beats.
    axis_pack_join u_join (
        .aclk     (aclk),
        .areset_n (areset_n),
        .cj_beat  (cj_beat),
        .cj_valid (cj_valid),
        .cj_ready (cj_ready),
        .tx_beat  (tx_beat),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

endmodule

// ==== dv/axis_pack_clk.sv ====
module axis_pack_clk (
    output logic aclk,
    output logic areset_n
);
    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;   // Period 100.
    end

    initial begin
        areset_n = 1'b0;
        repeat (8) @(posedge aclk);
        @(negedge aclk);            // Release away from the active edge.
        areset_n = 1'b1;
    end
endmodule

// ==== dv/axis_pack_vectors.svh ====
`ifndef AXIS_PACK_VECTORS_SVH
`define AXIS_PACK_VECTORS_SVH

localparam int n_in        = 23;    // Input beats.
localparam int n_out       = 17;    // Expected output beats.
localparam int bp_start    = 18;    // First input row of the back-pressure phase.
localparam int exp_flushes = 3;     // Packets that end with more than 4 bytes pending.

axis_beat_t in_rows [n_in];
axis_beat_t exp_rows [n_out];

task automatic load_vectors();
    // Row layout is {tdata, tkeep, tlast}; EE marks a null byte.
    in_rows[0]  = {32'h03020100, 4'b1111, 1'b0};   // Full beats.
    in_rows[1]  = {32'h07060504, 4'b1111, 1'b1};
    in_rows[2]  = {32'h11EE10EE, 4'b1010, 1'b0};   // Sparse keep.
    in_rows[3]  = {32'hEE1312EE, 4'b0110, 1'b0};
    in_rows[4]  = {32'hEE15EE14, 4'b0101, 1'b1};
    in_rows[5]  = {32'hEE222120, 4'b0111, 1'b0};   // Three bytes per beat.
    in_rows[6]  = {32'h252423EE, 4'b1110, 1'b0};
    in_rows[7]  = {32'h28EE2726, 4'b1011, 1'b0};
    in_rows[8]  = {32'h2B2AEE29, 4'b1101, 1'b1};
    in_rows[9]  = {32'hEE323130, 4'b0111, 1'b0};   // Six bytes, flush.
    in_rows[10] = {32'h353433EE, 4'b1110, 1'b1};
    in_rows[11] = {32'h4241EE40, 4'b1101, 1'b0};   // Seven bytes, flush.
    in_rows[12] = {32'h46454443, 4'b1111, 1'b1};
    in_rows[13] = {32'hEEEE5150, 4'b0011, 1'b0};   // Empty beat mid packet.
    in_rows[14] = {32'hEEEEEEEE, 4'b0000, 1'b0};
    in_rows[15] = {32'h5352EEEE, 4'b1100, 1'b1};
    in_rows[16] = {32'hEEEEEEEE, 4'b0000, 1'b0};   // Empty packet.
    in_rows[17] = {32'hEEEEEEEE, 4'b0000, 1'b1};
    in_rows[18] = {32'h63626160, 4'b1111, 1'b0};   // Back-pressure phase.
    in_rows[19] = {32'h65EEEE64, 4'b1001, 1'b0};
    in_rows[20] = {32'hEE686766, 4'b0111, 1'b0};
    in_rows[21] = {32'h6C6B6A69, 4'b1111, 1'b1};
    in_rows[22] = {32'hEE70EEEE, 4'b0100, 1'b1};

    exp_rows[0]  = {32'h03020100, 4'b1111, 1'b0};
    exp_rows[1]  = {32'h07060504, 4'b1111, 1'b1};
    exp_rows[2]  = {32'h13121110, 4'b1111, 1'b0};
    exp_rows[3]  = {32'h00001514, 4'b0011, 1'b1};
    exp_rows[4]  = {32'h23222120, 4'b1111, 1'b0};
    exp_rows[5]  = {32'h27262524, 4'b1111, 1'b0};
    exp_rows[6]  = {32'h2B2A2928, 4'b1111, 1'b1};
    exp_rows[7]  = {32'h33323130, 4'b1111, 1'b0};
    exp_rows[8]  = {32'h00003534, 4'b0011, 1'b1};
    exp_rows[9]  = {32'h43424140, 4'b1111, 1'b0};
    exp_rows[10] = {32'h00464544, 4'b0111, 1'b1};
    exp_rows[11] = {32'h53525150, 4'b1111, 1'b1};
    exp_rows[12] = {32'h63626160, 4'b1111, 1'b0};
    exp_rows[13] = {32'h67666564, 4'b1111, 1'b0};
    exp_rows[14] = {32'h6B6A6968, 4'b1111, 1'b0};
    exp_rows[15] = {32'h0000006C, 4'b0001, 1'b1};
    exp_rows[16] = {32'h00000070, 4'b0001, 1'b1};
endtask

`endif

// ==== dv/axis_pack_tb.sv ====
module axis_pack_tb;
    import axis_pack_pkg::*;

    `include "axis_pack_vectors.svh"

    logic       aclk;
    logic       areset_n;
    axis_beat_t rx_beat;
    logic       rx_valid;
    logic       rx_ready;
    axis_beat_t tx_beat;
    logic       tx_valid;
    logic       tx_ready;

    integer     seed = 22296;
    int         in_idx = 0;         // Row being offered on rx.
    int         out_idx = 0;        // Next expected tx row.
    int         bp_cycle = 0;
    int         flush_edges = 0;    // Enabled edges with rx refused.
    logic       refused_last = 1'b0;
    logic       hold_pending = 1'b0;
    axis_beat_t held_beat;

    axis_pack_clk u_clk (
        .aclk     (aclk),
        .areset_n (areset_n)
    );

    axis_pack u_dut (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rx_beat  (rx_beat),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_beat  (tx_beat),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input beat_data_t exp,
                              input beat_data_t act, input beat_keep_t keep);
        beat_data_t mask;
        mask = '0;
        for (int i = 0; i < lanes; i++) begin
            if (keep[i]) begin
                mask[8*i +: 8] = 8'hff;     // Null lanes carry no value.
            end
        end
        if ((exp & mask) !== (act & mask)) begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_keep(input string name, input beat_keep_t exp, input beat_keep_t act);
        if (exp !== act) begin
            $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic wait_transfer();
        int cycles;
        cycles = 0;
        do begin
            @(posedge aclk);
            cycles++;
            if (cycles > 1000) begin
                $display("Timeout: input row %0d not accepted within 1000 cycles", in_idx);
                abort_run();
            end
        end while (!rx_ready);
    endtask

    // Sink ready, random first, then long stalls.
    initial begin
        tx_ready = 1'b0;
        forever begin
            @(negedge aclk);
            if (in_idx >= bp_start) begin
                tx_ready = ((bp_cycle % 8) >= 5);   // Five low, three high.
                bp_cycle++;
            end else begin
                tx_ready = (($random(seed) & 3) != 0);
            end
        end
    end

    // Output checks on each rising edge.
    always @(posedge aclk) begin
        if (areset_n) begin
            if (hold_pending) begin
                if (!tx_valid) begin
                    $display("tx_valid dropped at %0t before the beat was taken", $time);
                    abort_run();
                end
                check_data("tx_beat.tdata held", held_beat.tdata, tx_beat.tdata, '1);
                check_keep("tx_beat.tkeep held", held_beat.tkeep, tx_beat.tkeep);
                check_last("tx_beat.tlast held", held_beat.tlast, tx_beat.tlast);
            end
            hold_pending = tx_valid && !tx_ready;
            held_beat    = tx_beat;

            if (tx_valid && tx_ready) begin
                if (out_idx >= n_out) begin
                    $display("Extra output beat at %0t beyond the expected table", $time);
                    abort_run();
                end
                check_data("tx_beat.tdata", exp_rows[out_idx].tdata, tx_beat.tdata,
                           exp_rows[out_idx].tkeep);
                check_keep("tx_beat.tkeep", exp_rows[out_idx].tkeep, tx_beat.tkeep);
                check_last("tx_beat.tlast", exp_rows[out_idx].tlast, tx_beat.tlast);
                out_idx++;
            end

            if (tx_ready) begin
                if (!rx_ready) begin
                    if (refused_last) begin
                        $display("rx_ready low on two enabled edges in a row at %0t", $time);
                        abort_run();
                    end
                    refused_last = 1'b1;
                    flush_edges++;
                end else begin
                    refused_last = 1'b0;
                end
            end
        end
    end

    initial begin
        int cycles;
        rx_beat  = '0;
        rx_valid = 1'b0;
        load_vectors();

        cycles = 0;
        while (areset_n !== 1'b1) begin
            @(posedge aclk);
            cycles++;
            if (cycles > 1000) begin
                $display("Timeout: reset was never released");
                abort_run();
            end
        end

        for (in_idx = 0; in_idx < n_in; in_idx++) begin
            @(negedge aclk);
            rx_beat  = in_rows[in_idx];
            rx_valid = 1'b1;
            wait_transfer();
        end
        @(negedge aclk);
        rx_valid = 1'b0;

        cycles = 0;
        while (out_idx < n_out) begin
            @(negedge aclk);
            cycles++;
            if (cycles > 1000) begin
                $display("Timeout: only %0d of %0d output beats seen", out_idx, n_out);
                abort_run();
            end
        end
        repeat (20) @(negedge aclk);    // Room for any stray beat.

        if (flush_edges == exp_flushes) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Flush count %0d, expected %0d", flush_edges, exp_flushes);
            $display("Simulation failed");
            $fatal(1, "end of run checks failed");
        end
    end
endmodule

// ==== axis_pack.f ====
+incdir+dv
hdl/axis_pack_pkg.sv
hdl/axis_pack_compact.sv
hdl/axis_pack_join.sv
hdl/axis_pack.sv
dv/axis_pack_clk.sv
dv/axis_pack_tb.sv
